// ==== source/uart_pkg.sv ====
// UART package: widths, FIFO sizing, FSM encodings, status bits and the host word layout
package uart_pkg;

    localparam int DATA_W = 8;
    localparam int DIV_W = 16;
    localparam int FIFO_DEPTH = 8;

    // 115200 baud from a 50 MHz clock
    localparam logic [DIV_W-1:0] DEFAULT_DIVIDE = 16'd434;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

    localparam int BIT_W = $clog2(DATA_W);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_W - 1);

    // Serial FSM states, shared by both engines
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;
    localparam logic [1:0] ST_STOP = 2'd3;

    // Status byte bit positions, bits 7..5 read as zero
    localparam int STAT_TX_NOT_FULL = 0;
    localparam int STAT_TX_EMPTY = 1;
    localparam int STAT_RX_NOT_EMPTY = 2;
    localparam int STAT_RX_FULL = 3;
    localparam int STAT_FRAME_ERR = 4;

    // Host data bus, read as a divisor on baud writes or a byte on data writes
    typedef union packed {
        logic [DIV_W-1:0] divisor;
        struct packed {
            logic [DIV_W-DATA_W-1:0] unused;
            logic [DATA_W-1:0] tx_data;
        } tx;
    } host_word_u;

endpackage

// ==== source/fifo_if.sv ====
// FIFO interface: push and pop strobes, data in both directions and the level flags
`timescale 1ns/1ns

interface fifo_if;
    import uart_pkg::*;

    logic wr;
    logic [DATA_W-1:0] wr_data;
    logic rd;
    logic [DATA_W-1:0] rd_data;
    logic empty;
    logic full;

    modport fifo (input wr, input wr_data, input rd,
                  output rd_data, output empty, output full);

    modport user (output wr, output wr_data, output rd,
                  input rd_data, input empty, input full);

endinterface

// ==== source/sync_fifo.sv ====
// Synchronous FIFO with first-word fall-through head and full/empty flags
`timescale 1ns/1ns

module sync_fifo (
    input logic clk,
    input logic rst,
    fifo_if.fifo q
);
    import uart_pkg::*;

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_wr;
    logic do_rd;

    // Overflow and underflow requests are dropped
    assign do_wr = q.wr && !q.full;
    assign do_rd = q.rd && !q.empty;

    assign q.empty = (count == '0);
    assign q.full = (count == FULL_CNT);
    assign q.rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= q.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // The user is expected to guard its own strobes
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(q.wr && q.full));
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(q.rd && q.empty));

endmodule

// ==== source/uart_tx.sv ====
// UART transmitter: sends one 8N1 frame per start pulse at the programmed bit period
`timescale 1ns/1ns

module uart_tx (
    input logic clk,
    input logic rst,
    input logic [uart_pkg::DIV_W-1:0] divisor,
    input logic start,
    input logic [uart_pkg::DATA_W-1:0] tx_byte,
    output logic tx,
    output logic busy
);
    import uart_pkg::*;

    logic [1:0] state;
    logic [DIV_W-1:0] cnt;
    logic [BIT_W-1:0] bit_idx;
    logic [DATA_W-1:0] shift;

    assign busy = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            tx <= 1'b1;
            cnt <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        shift <= tx_byte;
                        cnt <= divisor - 1'b1;
                        tx <= 1'b0;
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (cnt == '0) begin
                        // First data bit, LSB first
                        tx <= shift[0];
                        shift <= shift >> 1;
                        cnt <= divisor - 1'b1;
                        bit_idx <= '0;
                        state <= ST_DATA;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_DATA: begin
                    if (cnt == '0) begin
                        cnt <= divisor - 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            tx <= 1'b1;
                            state <= ST_STOP;
                        end else begin
                            tx <= shift[0];
                            shift <= shift >> 1;
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    // Stop bit, line already high
                    if (cnt == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

// ==== source/uart_rx.sv ====
// UART receiver: finds the start bit, samples at bit centers and flags bad stop bits
`timescale 1ns/1ns

module uart_rx (
    input logic clk,
    input logic rst,
    input logic [uart_pkg::DIV_W-1:0] divisor,
    input logic rx,
    output logic [uart_pkg::DATA_W-1:0] rx_byte,
    output logic received,
    output logic frame_err,
    output logic receiving
);
    import uart_pkg::*;

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    logic [1:0] state;
    logic [DIV_W-1:0] cnt;
    logic [BIT_W-1:0] bit_idx;

    assign receiving = (state != ST_IDLE);

    // Two-flop synchronizer plus edge history
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt <= '0;
            bit_idx <= '0;
            received <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            received <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (rx_prev && !rx_sync) begin
                        // Half period to land mid start bit
                        cnt <= divisor >> 1;
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (cnt == '0) begin
                        if (!rx_sync) begin
                            cnt <= divisor - 1'b1;
                            bit_idx <= '0;
                            state <= ST_DATA;
                        end else begin
                            // Glitch, not a real start bit
                            state <= ST_IDLE;
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_DATA: begin
                    if (cnt == '0) begin
                        rx_byte <= {rx_sync, rx_byte[DATA_W-1:1]};
                        cnt <= divisor - 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            state <= ST_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    if (cnt == '0) begin
                        received <= rx_sync;
                        frame_err <= !rx_sync;
                        state <= ST_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // Bit period must hold for the whole frame
    a_div_stable: assert property (@(posedge clk) disable iff (rst)
        receiving |=> $stable(divisor));

endmodule

// ==== source/uart_controller.sv ====
// UART controller: host registers, divisor, transmit pump and status around two FIFOs
`timescale 1ns/1ns

module uart_controller (
    input logic clk,
    input logic rst,
    input logic rx,
    input logic wr_en,
    input logic read,
    input logic baud_wr_en,
    input logic [15:0] data,
    output logic [uart_pkg::DATA_W-1:0] data_out,
    output logic [7:0] status_out,
    output logic tx,
    output logic uart_wait
);
    import uart_pkg::*;

    host_word_u host_word;
    logic [DIV_W-1:0] divisor;
    logic tx_start;
    logic tx_start_q;
    logic tx_busy;
    logic [DATA_W-1:0] rx_byte;
    logic rx_received;
    logic rx_frame_err;
    logic rx_receiving;
    logic [7:0] status_next;

    fifo_if tx_q ();
    fifo_if rx_q ();

    sync_fifo tx_fifo (
        .clk (clk),
        .rst (rst),
        .q   (tx_q.fifo)
    );

    sync_fifo rx_fifo (
        .clk (clk),
        .rst (rst),
        .q   (rx_q.fifo)
    );

    uart_tx uart_tx_inst (
        .clk     (clk),
        .rst     (rst),
        .divisor (divisor),
        .start   (tx_start),
        .tx_byte (tx_q.rd_data),
        .tx      (tx),
        .busy    (tx_busy)
    );

    uart_rx uart_rx_inst (
        .clk       (clk),
        .rst       (rst),
        .divisor   (divisor),
        .rx        (rx),
        .rx_byte   (rx_byte),
        .received  (rx_received),
        .frame_err (rx_frame_err),
        .receiving (rx_receiving)
    );

    assign host_word = data;

    // Host push, dropped when the transmit FIFO is full
    assign tx_q.wr = wr_en && !tx_q.full;
    assign tx_q.wr_data = host_word.tx.tx_data;

    // Transmit pump, one start per idle gap
    assign tx_start = !tx_q.empty && !tx_busy && !tx_start_q;
    assign tx_q.rd = tx_start;

    // Received bytes are lost when the receive FIFO is full
    assign rx_q.wr = rx_received && !rx_q.full;
    assign rx_q.wr_data = rx_byte;
    assign rx_q.rd = read && !rx_q.empty;
    assign data_out = rx_q.rd_data;

    always_comb begin
        status_next = '0;
        status_next[STAT_TX_NOT_FULL] = !tx_q.full;
        status_next[STAT_TX_EMPTY] = tx_q.empty;
        status_next[STAT_RX_NOT_EMPTY] = !rx_q.empty;
        status_next[STAT_RX_FULL] = rx_q.full;
        // Sticky until a read, a new error wins over the clear
        status_next[STAT_FRAME_ERR] = rx_frame_err || (status_out[STAT_FRAME_ERR] && !read);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            divisor <= DEFAULT_DIVIDE;
            tx_start_q <= 1'b0;
            uart_wait <= 1'b0;
            status_out <= '0;
        end else begin
            tx_start_q <= tx_start;
            status_out <= status_next;
            if (wr_en) begin
                uart_wait <= tx_q.full;
            end
            if (baud_wr_en) begin
                divisor <= host_word.divisor;
            end
        end
    end

    // Divisor may only change between frames in both directions
    a_baud_idle: assert property (@(posedge clk) disable iff (rst)
        baud_wr_en |-> !tx_busy && !rx_receiving);

endmodule

// ==== tests/uart_controller_tb.sv ====
// UART controller testbench: table-driven loopback, overflow and framing checks with a tx decoder
`timescale 1ns/1ns

module uart_controller_tb;
    import uart_pkg::*;

    localparam int TB_DIV = 8;
    localparam int FRAME_CYC = 10 * TB_DIV;
    localparam int WAIT_CYC = 3 * FRAME_CYC;
    localparam int TABLE_LEN = 8;
    localparam int RESET_CYC = 16;
    localparam int TIMEOUT_NS = (RESET_CYC + TABLE_LEN * 12 * FRAME_CYC) * 4;
    localparam logic [7:0] IDLE_STATUS = (8'd1 << STAT_TX_NOT_FULL) | (8'd1 << STAT_TX_EMPTY);

    localparam int MODE_LOOP = 0;
    localparam int MODE_BURST = 1;
    localparam int MODE_FERR = 2;
    localparam int MODE_DIRECT = 3;

    logic clk;
    logic rst;
    logic rx;
    logic wr_en;
    logic read;
    logic baud_wr_en;
    logic [15:0] data;
    logic [DATA_W-1:0] data_out;
    logic [7:0] status_out;
    logic tx;
    logic uart_wait;

    // Serial line model
    logic loop_sel;
    logic gen_line;
    int bit_cycles;
    logic [DATA_W-1:0] dec_q [$];
    logic [9:0] dec_bits;
    logic dec_first;
    logic dec_stable;

    integer seed;
    int err_count;
    int check_count;
    int fail_tests;

    // Expected status for loop and direct entries, expected flag for the others
    int tbl_mode [TABLE_LEN] = '{MODE_LOOP, MODE_LOOP, MODE_LOOP, MODE_LOOP,
                                 MODE_BURST, MODE_FERR, MODE_DIRECT, MODE_LOOP};
    logic [7:0] tbl_byte [TABLE_LEN] = '{8'hA5, 8'h00, 8'hFF, 8'h3C,
                                         8'h00, 8'h5A, 8'hC3, 8'h81};
    logic [7:0] tbl_expect [TABLE_LEN] = '{IDLE_STATUS, IDLE_STATUS, IDLE_STATUS, IDLE_STATUS,
                                           8'd1, 8'd1, IDLE_STATUS, IDLE_STATUS};

    uart_controller uart_controller_inst (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .wr_en      (wr_en),
        .read       (read),
        .baud_wr_en (baud_wr_en),
        .data       (data),
        .data_out   (data_out),
        .status_out (status_out),
        .tx         (tx),
        .uart_wait  (uart_wait)
    );

    assign rx = loop_sel ? tx : gen_line;

    always #2 clk = ~clk;

    task automatic check(input logic [15:0] actual, input logic [15:0] expected,
                         input string msg);
        check_count++;
        if (actual !== expected) begin
            $display("ERR @%0t: %s, got %h expected %h", $time, msg, actual, expected);
            err_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic program_divisor(input int div);
        data = div[15:0];
        baud_wr_en = 1'b1;
        next_cycle();
        baud_wr_en = 1'b0;
        bit_cycles = div;
    endtask

    task automatic host_write(input logic [7:0] b);
        data = {8'($random(seed)), b};
        wr_en = 1'b1;
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic host_read();
        read = 1'b1;
        next_cycle();
        read = 1'b0;
    endtask

    task automatic send_frame(input logic [7:0] b, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, b, 1'b0};
        for (int k = 0; k < 10; k++) begin
            gen_line = frame[k];
            repeat (TB_DIV) next_cycle();
        end
        gen_line = 1'b1;
    endtask

    task automatic wait_status(input int bit_pos, input logic value, input string what);
        int n;
        n = 0;
        while (status_out[bit_pos] !== value && n < WAIT_CYC) begin
            next_cycle();
            n++;
        end
        if (status_out[bit_pos] !== value) begin
            $display("Timed out at %0t waiting for %s", $time, what);
            err_count++;
        end
    endtask

    task automatic wait_decoded(input int count, input int limit);
        int n;
        n = 0;
        while (dec_q.size() < count && n < limit) begin
            next_cycle();
            n++;
        end
        if (dec_q.size() < count) begin
            $display("Timed out at %0t: only %0d of %0d frames seen on tx",
                     $time, dec_q.size(), count);
            err_count++;
        end
    endtask

    // Sample every half cycle point of each bit, value taken at the center
    initial begin
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                dec_stable = 1'b1;
                for (int k = 0; k < 10; k++) begin
                    for (int s = 0; s < bit_cycles; s++) begin
                        if (k != 0 || s != 0) begin
                            @(negedge clk);
                        end
                        if (s == 0) begin
                            dec_first = tx;
                        end else if (tx !== dec_first) begin
                            dec_stable = 1'b0;
                        end
                        if (s == bit_cycles / 2) begin
                            dec_bits[k] = tx;
                        end
                    end
                end
                check(dec_stable, 1'b1, "tx bit held for one divisor");
                check(dec_bits[9], 1'b1, "tx stop bit");
                dec_q.push_back(dec_bits[8:1]);
            end
        end
    end

    task automatic run_entry(input int idx);
        int mode;
        logic [7:0] b;
        logic [7:0] exp;
        logic saw_wait;
        logic [7:0] sent [$];
        mode = tbl_mode[idx];
        b = tbl_byte[idx];
        exp = tbl_expect[idx];
        dec_q.delete();
        case (mode)
            MODE_LOOP: begin
                loop_sel = 1'b1;
                host_write(b);
                wait_decoded(1, WAIT_CYC);
                if (dec_q.size() > 0) begin
                    check(dec_q[0], b, "byte decoded from tx");
                end
                wait_status(STAT_RX_NOT_EMPTY, 1'b1, "loopback byte");
                check(data_out, b, "loopback byte on data_out");
                host_read();
                next_cycle();
                check(status_out, exp, "status after loopback read");
            end
            MODE_BURST: begin
                loop_sel = 1'b0;
                saw_wait = 1'b0;
                for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
                    b = $random(seed);
                    data = {8'h00, b};
                    wr_en = 1'b1;
                    next_cycle();
                    if (uart_wait) begin
                        saw_wait = 1'b1;
                    end else begin
                        sent.push_back(b);
                    end
                end
                wr_en = 1'b0;
                check(saw_wait, exp[0], "uart_wait after overflow");
                wait_decoded(sent.size(), (sent.size() + 2) * FRAME_CYC);
                // Quiet time, no extra frame may follow
                repeat (2 * FRAME_CYC) next_cycle();
                check(dec_q.size(), sent.size(), "frames seen versus writes accepted");
                for (int i = 0; i < sent.size() && i < dec_q.size(); i++) begin
                    check(dec_q[i], sent[i], "burst byte order on tx");
                end
            end
            MODE_FERR: begin
                loop_sel = 1'b0;
                send_frame(b, 1'b0);
                wait_status(STAT_FRAME_ERR, 1'b1, "framing error flag");
                check(status_out[STAT_FRAME_ERR], exp[0], "framing error flag set");
                check(status_out[STAT_RX_NOT_EMPTY], 1'b0, "bad frame kept out of rx FIFO");
                host_read();
                next_cycle();
                check(status_out[STAT_FRAME_ERR], 1'b0, "framing error cleared by read");
            end
            default: begin
                loop_sel = 1'b0;
                send_frame(b, 1'b1);
                wait_status(STAT_RX_NOT_EMPTY, 1'b1, "directly driven byte");
                check(data_out, b, "direct byte on data_out");
                host_read();
                next_cycle();
                check(status_out, exp, "status after direct read");
            end
        endcase
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns before all tests finished", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int errs_before;
        clk = 1'b0;
        rst = 1'b1;
        wr_en = 1'b0;
        read = 1'b0;
        baud_wr_en = 1'b0;
        data = '0;
        loop_sel = 1'b1;
        gen_line = 1'b1;
        bit_cycles = TB_DIV;
        seed = 32'h1858;
        err_count = 0;
        check_count = 0;
        fail_tests = 0;

        repeat (RESET_CYC) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();
        next_cycle();

        errs_before = err_count;
        check(tx, 1'b1, "tx idle after reset");
        check(uart_wait, 1'b0, "uart_wait after reset");
        check(status_out, IDLE_STATUS, "status after reset");
        if (err_count != errs_before) begin
            fail_tests++;
        end
        $display("Reset defaults: %s", (err_count == errs_before) ? "ok" : "failed");

        program_divisor(TB_DIV);

        for (int i = 0; i < TABLE_LEN; i++) begin
            errs_before = err_count;
            run_entry(i);
            if (err_count != errs_before) begin
                fail_tests++;
            end
            $display("Test %0d mode %0d byte %h: %s", i, tbl_mode[i], tbl_byte[i],
                     (err_count == errs_before) ? "ok" : "failed");
        end

        $display("Done: %0d tests, %0d failed, %0d checks, %0d errors",
                 TABLE_LEN + 1, fail_tests, check_count, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== uart_ctrl.f ====
source/uart_pkg.sv
source/fifo_if.sv
source/sync_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_controller.sv
tests/uart_controller_tb.sv
